// ==== uart.f ====
common/uart_pkg.sv
uart_core/uart_fifo.sv
uart_core/uart_tx.sv
uart_core/uart_rx.sv
uart_core/uart_regs.sv
src/uart_apb.sv
verif/uart_checker.sv
verif/uart_tb.sv

// ==== Makefile ====
SRCS := $(wildcard common/*.sv src/*.sv uart_core/*.sv verif/*.sv)

.PHONY: run clean

run: obj_dir/Vuart_tb
	obj_dir/Vuart_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "ERRORS FOUND" sim.log

obj_dir/Vuart_tb: $(SRCS) uart.f
	verilator --binary --timing --assert --top-module uart_tb -f uart.f -Mdir obj_dir -o Vuart_tb

clean:
	rm -rf obj_dir sim.log

// ==== verif/uart_tb.sv ====
`timescale 1ns/100ps

module uart_tb;

	localparam int CLK_PERIOD = 8;
	localparam int BIT_CLKS = 8;
	// 20 frames of 10 bits plus margin
	localparam int TIMEOUT_CYCLES = 20 * 10 * BIT_CLKS + 2000;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic txd;
	logic rxd;
	logic cts;
	logic dsr;
	logic dcd;
	logic ri;
	logic rts;
	logic dtr;
	logic irq;

	// Line select between loopback and direct drive
	logic line_sel;
	logic rxd_drv;
	assign rxd = line_sel ? txd : rxd_drv;

	// Model state
	int m_tx_cnt;
	int m_rx_cnt;
	logic m_ovr;
	logic m_fe;
	logic [uart_pkg::CTRL_W-1:0] m_ctrl;
	logic [uart_pkg::DATA_W-1:0] exp_q[$];

	int err_data;
	int err_reg;
	int err_bit;
	int cycles;

	uart_apb uart_apb_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.txd(txd),
		.rxd(rxd),
		.cts(cts),
		.dsr(dsr),
		.dcd(dcd),
		.ri(ri),
		.rts(rts),
		.dtr(dtr),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ************************************************************
	// Reference model
	// ************************************************************
	function automatic logic [15:0] ref_status(input logic busy);
		logic [15:0] s;
		s = '0;
		s[uart_pkg::ST_TX_EMPTY] = (m_tx_cnt == 0);
		s[uart_pkg::ST_TX_FULL] = (m_tx_cnt == uart_pkg::FIFO_DEPTH);
		s[uart_pkg::ST_RX_EMPTY] = (m_rx_cnt == 0);
		s[uart_pkg::ST_RX_FULL] = (m_rx_cnt == uart_pkg::FIFO_DEPTH);
		s[uart_pkg::ST_OVERRUN] = m_ovr;
		s[uart_pkg::ST_FRAME_ERR] = m_fe;
		s[uart_pkg::ST_TX_BUSY] = busy;
		// Modem pins straight from the line side
		s[uart_pkg::ST_CTS] = cts;
		s[uart_pkg::ST_DSR] = dsr;
		s[uart_pkg::ST_DCD] = dcd;
		s[uart_pkg::ST_RI] = ri;
		return s;
	endfunction

	function automatic logic ref_irq(input logic [uart_pkg::IRQ_EN_W-1:0] en);
		return ((m_rx_cnt != 0) && en[uart_pkg::IRQ_RX_AVAIL]) ||
			((m_tx_cnt == 0) && en[uart_pkg::IRQ_TX_EMPTY]) ||
			((m_ovr || m_fe) && en[uart_pkg::IRQ_ERROR]);
	endfunction

	// ************************************************************
	// Compare tasks
	// ************************************************************
	task automatic check_data(input string name, input logic [uart_pkg::DATA_W-1:0] exp,
		input logic [uart_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
			err_data++;
		end
	endtask

	task automatic check_reg(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
			err_reg++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %b, actual %b", $time, name, exp, act);
			err_bit++;
		end
	endtask

	// ************************************************************
	// Bus and line tasks
	// ************************************************************
	task automatic bus_write(input uart_pkg::uart_reg_e idx, input logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = {27'd0, idx, 2'b00};
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		// Register updates on this edge
		@(posedge clk);
		if (idx == uart_pkg::REG_CTRL)
			m_ctrl = data[uart_pkg::CTRL_W-1:0];
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic bus_read(input uart_pkg::uart_reg_e idx, output logic [15:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = {27'd0, idx, 2'b00};
		@(negedge clk);
		penable = 1'b1;
		// Sample mid access phase before the pop edge
		#(CLK_PERIOD / 4);
		data = prdata[15:0];
		check_reg("prdata[31:16]", 16'd0, prdata[31:16]);
		check_bit("pready", 1'b1, pready);
		check_bit("pslverr", 1'b0, pslverr);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic verify_status(input logic busy);
		logic [15:0] v;
		bus_read(uart_pkg::REG_STATUS, v);
		check_reg("STATUS", ref_status(busy), v);
	endtask

	// Polls STATUS until the bit reaches the value
	task automatic poll_status(input int bit_pos, input logic value);
		logic [15:0] v;
		do begin
			bus_read(uart_pkg::REG_STATUS, v);
		end while (v[bit_pos] !== value);
	endtask

	task automatic drive_frame(input logic [uart_pkg::DATA_W-1:0] data, input logic stop_bit);
		logic [9:0] frame;
		int i;
		// Start bit, LSB first data, stop bit
		frame = {stop_bit, data, 1'b0};
		line_sel = 1'b0;
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			rxd_drv = frame[i];
			repeat (BIT_CLKS - 1) @(negedge clk);
		end
		@(negedge clk);
		rxd_drv = 1'b1;
	endtask

	// rts and dtr follow the model CTRL at all times
	always @(negedge clk) begin
		if (!reset) begin
			check_bit("rts", m_ctrl[uart_pkg::CTRL_RTS], rts);
			check_bit("dtr", m_ctrl[uart_pkg::CTRL_DTR], dtr);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ************************************************************
	// Tests
	// ************************************************************
	initial begin
		logic [31:0] rnd;
		logic [15:0] v;
		logic [uart_pkg::IRQ_EN_W-1:0] en;
		int i;
		int total;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		cts = 1'b0;
		dsr = 1'b0;
		dcd = 1'b0;
		ri = 1'b0;
		line_sel = 1'b0;
		rxd_drv = 1'b1;
		m_tx_cnt = 0;
		m_rx_cnt = 0;
		m_ovr = 1'b0;
		m_fe = 1'b0;
		m_ctrl = '0;
		err_data = 0;
		err_reg = 0;
		err_bit = 0;
		cycles = 0;
		rnd = $urandom(32'hb89fcc46);
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Reset values then random writes read back masked
		bus_read(uart_pkg::REG_CTRL, v);
		check_reg("CTRL", 16'd0, v);
		bus_read(uart_pkg::REG_IRQ_EN, v);
		check_reg("IRQ_EN", 16'd0, v);
		bus_read(uart_pkg::REG_BAUD, v);
		check_reg("BAUD", uart_pkg::BAUD_RESET, v);
		verify_status(1'b0);
		for (i = 0; i < 4; i++) begin
			rnd = $urandom;
			bus_write(uart_pkg::REG_CTRL, rnd);
			bus_read(uart_pkg::REG_CTRL, v);
			check_reg("CTRL", 16'(rnd[uart_pkg::CTRL_W-1:0]), v);
			rnd = $urandom;
			bus_write(uart_pkg::REG_BAUD, rnd);
			bus_read(uart_pkg::REG_BAUD, v);
			check_reg("BAUD", rnd[uart_pkg::DIV_W-1:0], v);
			rnd = $urandom;
			bus_write(uart_pkg::REG_IRQ_EN, rnd);
			bus_read(uart_pkg::REG_IRQ_EN, v);
			check_reg("IRQ_EN", 16'(rnd[uart_pkg::IRQ_EN_W-1:0]), v);
		end

		// Loopback returns bytes in order
		line_sel = 1'b1;
		bus_write(uart_pkg::REG_BAUD, BIT_CLKS);
		bus_write(uart_pkg::REG_CTRL, (1 << uart_pkg::CTRL_TX_EN) | (1 << uart_pkg::CTRL_RX_EN));
		for (i = 0; i < 3; i++) begin
			rnd = $urandom;
			bus_write(uart_pkg::REG_DATA, 32'(rnd[uart_pkg::DATA_W-1:0]));
			exp_q.push_back(rnd[uart_pkg::DATA_W-1:0]);
		end
		for (i = 0; i < 3; i++) begin
			poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
			bus_read(uart_pkg::REG_DATA, v);
			check_data("DATA", exp_q.pop_front(), v[uart_pkg::DATA_W-1:0]);
		end
		verify_status(1'b0);

		// Transmitter held off so the ninth push drops
		bus_write(uart_pkg::REG_CTRL, 1 << uart_pkg::CTRL_RX_EN);
		for (i = 0; i < 9; i++) begin
			rnd = $urandom;
			bus_write(uart_pkg::REG_DATA, 32'(rnd[uart_pkg::DATA_W-1:0]));
			if (m_tx_cnt < uart_pkg::FIFO_DEPTH) begin
				m_tx_cnt++;
				exp_q.push_back(rnd[uart_pkg::DATA_W-1:0]);
			end
			verify_status(1'b0);
		end
		bus_write(uart_pkg::REG_CTRL, (1 << uart_pkg::CTRL_TX_EN) | (1 << uart_pkg::CTRL_RX_EN));
		poll_status(uart_pkg::ST_TX_BUSY, 1'b0);
		// Eight frames fill the receive FIFO with no overrun
		m_tx_cnt = 0;
		m_rx_cnt = uart_pkg::FIFO_DEPTH;
		verify_status(1'b0);

		// One more frame overruns
		rnd = $urandom;
		drive_frame(rnd[uart_pkg::DATA_W-1:0], 1'b1);
		poll_status(uart_pkg::ST_OVERRUN, 1'b1);
		m_ovr = 1'b1;
		verify_status(1'b0);
		for (i = 0; i < uart_pkg::FIFO_DEPTH; i++) begin
			bus_read(uart_pkg::REG_DATA, v);
			check_data("DATA", exp_q.pop_front(), v[uart_pkg::DATA_W-1:0]);
			m_rx_cnt--;
		end
		// Empty FIFO reads as zero
		bus_read(uart_pkg::REG_DATA, v);
		check_data("DATA", '0, v[uart_pkg::DATA_W-1:0]);
		verify_status(1'b0);
		bus_write(uart_pkg::REG_STATUS, 1 << uart_pkg::ST_OVERRUN);
		m_ovr = 1'b0;
		verify_status(1'b0);

		// Bad stop bit pushes nothing
		rnd = $urandom;
		drive_frame(rnd[uart_pkg::DATA_W-1:0], 1'b0);
		poll_status(uart_pkg::ST_FRAME_ERR, 1'b1);
		m_fe = 1'b1;
		verify_status(1'b0);
		bus_write(uart_pkg::REG_IRQ_EN, 0);
		@(negedge clk);
		check_bit("irq", ref_irq('0), irq);
		// One enable at a time from error down to rx available
		for (i = 1; i <= uart_pkg::IRQ_EN_W; i++) begin
			en = 3'(1 << (uart_pkg::IRQ_EN_W - i));
			bus_write(uart_pkg::REG_IRQ_EN, 32'(en));
			@(negedge clk);
			check_bit("irq", ref_irq(en), irq);
		end
		rnd = $urandom;
		drive_frame(rnd[uart_pkg::DATA_W-1:0], 1'b1);
		poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
		m_rx_cnt = 1;
		@(negedge clk);
		check_bit("irq", ref_irq(en), irq);
		bus_read(uart_pkg::REG_DATA, v);
		check_data("DATA", rnd[uart_pkg::DATA_W-1:0], v[uart_pkg::DATA_W-1:0]);
		m_rx_cnt = 0;
		bus_write(uart_pkg::REG_STATUS, 1 << uart_pkg::ST_FRAME_ERR);
		bus_write(uart_pkg::REG_IRQ_EN, 0);
		m_fe = 1'b0;
		verify_status(1'b0);

		// Flow control holds the byte until cts rises
		line_sel = 1'b1;
		cts = 1'b0;
		bus_write(uart_pkg::REG_CTRL, (1 << uart_pkg::CTRL_TX_EN) | (1 << uart_pkg::CTRL_RX_EN) |
			(1 << uart_pkg::CTRL_FLOW_EN) | (1 << uart_pkg::CTRL_RTS) | (1 << uart_pkg::CTRL_DTR));
		rnd = $urandom;
		bus_write(uart_pkg::REG_DATA, 32'(rnd[uart_pkg::DATA_W-1:0]));
		m_tx_cnt = 1;
		repeat (3 * BIT_CLKS) begin
			@(negedge clk);
			check_bit("txd", 1'b1, txd);
		end
		dsr = 1'b1;
		ri = 1'b1;
		verify_status(1'b0);
		cts = 1'b1;
		dcd = 1'b1;
		// Frame starts at once and pops the byte
		m_tx_cnt = 0;
		verify_status(1'b1);
		poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
		bus_read(uart_pkg::REG_DATA, v);
		check_data("DATA", rnd[uart_pkg::DATA_W-1:0], v[uart_pkg::DATA_W-1:0]);
		verify_status(1'b0);

		total = err_data + err_reg + err_bit;
		$display("Error counts: data %0d, register %0d, pin %0d", err_data, err_reg, err_bit);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verif/uart_checker.sv ====
`timescale 1ns/100ps

module uart_checker (
	input logic clk,
	input logic reset,
	input logic pready,
	input logic pslverr,
	input logic txd,
	input logic rx_push,
	input logic rx_full,
	input logic irq,
	input logic [uart_pkg::IRQ_EN_W-1:0] irq_en
);

	// ************************************************************
	// Bus response and line idle
	// ************************************************************
	// Every access completes at once without error
	a_bus_resp: assert property (@(posedge clk) pready && !pslverr)
		else $error("Bus response not ready or flagged as an error");

	// Line returns to idle under reset
	a_txd_idle: assert property (@(posedge clk) reset |=> txd)
		else $error("Serial output not idle after reset");

	// Receiver never pushes into a full FIFO
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		!(rx_push && rx_full))
		else $error("Receive FIFO pushed while full");

	// Registered interrupt, so masked one cycle later
	a_irq_masked: assert property (@(posedge clk) disable iff (reset)
		(irq_en == '0) |=> !irq)
		else $error("Interrupt raised with all enables clear");

endmodule

bind uart_apb uart_checker checker_i (
	.clk(clk),
	.reset(reset),
	.pready(pready),
	.pslverr(pslverr),
	.txd(txd),
	.rx_push(rx_push),
	.rx_full(rx_full),
	.irq(irq),
	.irq_en(regs_i.irq_en)
);

// ==== src/uart_apb.sv ====
`timescale 1ns/100ps

module uart_apb (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic txd,
	input logic rxd,
	input logic cts,
	input logic dsr,
	input logic dcd,
	input logic ri,
	output logic rts,
	output logic dtr,
	output logic irq
);

	// Bus side
	logic wen;
	logic ren;
	uart_pkg::uart_reg_e reg_index;
	logic [15:0] reg_rdata;

	// FIFO side
	logic tx_push;
	logic [uart_pkg::DATA_W-1:0] tx_wdata;
	logic tx_pop;
	logic [uart_pkg::DATA_W-1:0] tx_data;
	logic tx_empty;
	logic tx_full;
	logic rx_push;
	logic [uart_pkg::DATA_W-1:0] rx_byte;
	logic rx_pop;
	logic [uart_pkg::DATA_W-1:0] rx_head;
	logic rx_empty;
	logic rx_full;

	// Control and line status
	logic [uart_pkg::DIV_W-1:0] baud_div;
	logic tx_en;
	logic rx_en;
	logic flow_en;
	logic tx_busy;
	logic frame_err_pulse;
	logic overrun_pulse;

	// ************************************************************
	// Bus decode
	// ************************************************************
	// Access phase strobes
	assign wen = psel && penable && pwrite;
	assign ren = psel && penable && !pwrite;
	// Word addressed registers
	assign reg_index = uart_pkg::uart_reg_e'(paddr[2 +: uart_pkg::REG_INDEX_W]);
	assign prdata = {16'd0, reg_rdata};

	// Single cycle access, never an error
	assign pready = 1'b1;
	assign pslverr = 1'b0;

	uart_regs regs_i (
		.clk(clk),
		.reset(reset),
		.wen(wen),
		.ren(ren),
		.index(reg_index),
		.wdata(pwdata),
		.tx_empty(tx_empty),
		.tx_full(tx_full),
		.rx_empty(rx_empty),
		.rx_full(rx_full),
		.rx_head(rx_head),
		.tx_busy(tx_busy),
		.frame_err_pulse(frame_err_pulse),
		.overrun_pulse(overrun_pulse),
		.cts(cts),
		.dsr(dsr),
		.dcd(dcd),
		.ri(ri),
		.rdata(reg_rdata),
		.tx_push(tx_push),
		.tx_wdata(tx_wdata),
		.rx_pop(rx_pop),
		.baud_div(baud_div),
		.tx_en(tx_en),
		.rx_en(rx_en),
		.flow_en(flow_en),
		.rts(rts),
		.dtr(dtr),
		.irq(irq)
	);

	// ************************************************************
	// Transmit path
	// ************************************************************
	uart_fifo tx_fifo_i (
		.clk(clk),
		.reset(reset),
		.push(tx_push),
		.wdata(tx_wdata),
		.pop(tx_pop),
		.rdata(tx_data),
		.empty(tx_empty),
		.full(tx_full),
		.count()
	);

	uart_tx tx_i (
		.clk(clk),
		.reset(reset),
		.tx_en(tx_en),
		.flow_en(flow_en),
		.cts(cts),
		.baud_div(baud_div),
		.fifo_empty(tx_empty),
		.fifo_data(tx_data),
		.fifo_pop(tx_pop),
		.txd(txd),
		.busy(tx_busy)
	);

	// ************************************************************
	// Receive path
	// ************************************************************
	uart_fifo rx_fifo_i (
		.clk(clk),
		.reset(reset),
		.push(rx_push),
		.wdata(rx_byte),
		.pop(rx_pop),
		.rdata(rx_head),
		.empty(rx_empty),
		.full(rx_full),
		.count()
	);

	uart_rx rx_i (
		.clk(clk),
		.reset(reset),
		.rx_en(rx_en),
		.baud_div(baud_div),
		.rxd(rxd),
		.fifo_full(rx_full),
		.push(rx_push),
		.byte_out(rx_byte),
		.frame_err_pulse(frame_err_pulse),
		.overrun_pulse(overrun_pulse)
	);

endmodule

// ==== uart_core/uart_regs.sv ====
`timescale 1ns/100ps

module uart_regs (
	input logic clk,
	input logic reset,
	input logic wen,
	input logic ren,
	input uart_pkg::uart_reg_e index,
	input logic [31:0] wdata,
	input logic tx_empty,
	input logic tx_full,
	input logic rx_empty,
	input logic rx_full,
	input logic [uart_pkg::DATA_W-1:0] rx_head,
	input logic tx_busy,
	input logic frame_err_pulse,
	input logic overrun_pulse,
	input logic cts,
	input logic dsr,
	input logic dcd,
	input logic ri,
	output logic [15:0] rdata,
	output logic tx_push,
	output logic [uart_pkg::DATA_W-1:0] tx_wdata,
	output logic rx_pop,
	output logic [uart_pkg::DIV_W-1:0] baud_div,
	output logic tx_en,
	output logic rx_en,
	output logic flow_en,
	output logic rts,
	output logic dtr,
	output logic irq
);

	logic [uart_pkg::CTRL_W-1:0] ctrl;
	logic [uart_pkg::IRQ_EN_W-1:0] irq_en;
	logic overrun_flag;
	logic frame_err_flag;
	logic status_wen;
	logic [15:0] status;

	// ************************************************************
	// DATA register side effects
	// ************************************************************
	// Push on write, full case dropped inside the FIFO
	assign tx_push = wen && (index == uart_pkg::REG_DATA);
	assign tx_wdata = wdata[uart_pkg::DATA_W-1:0];
	// Pop only when something is there
	assign rx_pop = ren && (index == uart_pkg::REG_DATA) && !rx_empty;

	// Control register fields
	assign tx_en = ctrl[uart_pkg::CTRL_TX_EN];
	assign rx_en = ctrl[uart_pkg::CTRL_RX_EN];
	assign flow_en = ctrl[uart_pkg::CTRL_FLOW_EN];
	assign rts = ctrl[uart_pkg::CTRL_RTS];
	assign dtr = ctrl[uart_pkg::CTRL_DTR];

	assign status_wen = wen && (index == uart_pkg::REG_STATUS);

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
			irq_en <= '0;
			baud_div <= uart_pkg::BAUD_RESET;
		end else if (wen) begin
			case (index)
				uart_pkg::REG_CTRL: ctrl <= wdata[uart_pkg::CTRL_W-1:0];
				uart_pkg::REG_BAUD: baud_div <= wdata[uart_pkg::DIV_W-1:0];
				uart_pkg::REG_IRQ_EN: irq_en <= wdata[uart_pkg::IRQ_EN_W-1:0];
				default: ;
			endcase
		end
	end

	// Sticky error flags, a new event wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			overrun_flag <= 1'b0;
			frame_err_flag <= 1'b0;
		end else begin
			overrun_flag <= overrun_pulse ||
				(overrun_flag && !(status_wen && wdata[uart_pkg::ST_OVERRUN]));
			frame_err_flag <= frame_err_pulse ||
				(frame_err_flag && !(status_wen && wdata[uart_pkg::ST_FRAME_ERR]));
		end
	end

	// ************************************************************
	// Status word and read mux
	// ************************************************************
	always_comb begin
		status = '0;
		status[uart_pkg::ST_TX_EMPTY] = tx_empty;
		status[uart_pkg::ST_TX_FULL] = tx_full;
		status[uart_pkg::ST_RX_EMPTY] = rx_empty;
		status[uart_pkg::ST_RX_FULL] = rx_full;
		status[uart_pkg::ST_OVERRUN] = overrun_flag;
		status[uart_pkg::ST_FRAME_ERR] = frame_err_flag;
		status[uart_pkg::ST_TX_BUSY] = tx_busy;
		// Modem pins, read as they are
		status[uart_pkg::ST_CTS] = cts;
		status[uart_pkg::ST_DSR] = dsr;
		status[uart_pkg::ST_DCD] = dcd;
		status[uart_pkg::ST_RI] = ri;
	end

	always_comb begin
		case (index)
			// Empty FIFO reads as zero
			uart_pkg::REG_DATA: rdata = rx_empty ? 16'd0 : 16'(rx_head);
			uart_pkg::REG_STATUS: rdata = status;
			uart_pkg::REG_CTRL: rdata = 16'(ctrl);
			uart_pkg::REG_BAUD: rdata = 16'(baud_div);
			uart_pkg::REG_IRQ_EN: rdata = 16'(irq_en);
			default: rdata = 16'd0;
		endcase
	end

	// Registered interrupt
	always_ff @(posedge clk) begin
		if (reset) begin
			irq <= 1'b0;
		end else begin
			irq <= (!rx_empty && irq_en[uart_pkg::IRQ_RX_AVAIL]) ||
				(tx_empty && irq_en[uart_pkg::IRQ_TX_EMPTY]) ||
				((overrun_flag || frame_err_flag) && irq_en[uart_pkg::IRQ_ERROR]);
		end
	end

endmodule

// ==== uart_core/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
	input logic clk,
	input logic reset,
	input logic rx_en,
	input logic [uart_pkg::DIV_W-1:0] baud_div,
	input logic rxd,
	input logic fifo_full,
	output logic push,
	output logic [uart_pkg::DATA_W-1:0] byte_out,
	output logic frame_err_pulse,
	output logic overrun_pulse
);

	uart_pkg::rx_state_e state;
	// Two flop synchronizer plus one for edge detect
	logic rxd_meta;
	logic rxd_sync;
	logic rxd_last;
	logic [uart_pkg::DIV_W-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic bit_done;
	logic half_done;
	logic frame_done;
	logic stop_ok;

	assign bit_done = (baud_cnt == baud_div - 1'b1);
	// Middle of the start bit
	assign half_done = (baud_cnt == (baud_div >> 1));

	// Decision one cycle after the stop sample
	assign push = frame_done && stop_ok && !fifo_full;
	assign overrun_pulse = frame_done && stop_ok && fifo_full;
	assign frame_err_pulse = frame_done && !stop_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	// ************************************************************
	// Receive FSM
	// ************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::RX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				uart_pkg::RX_IDLE: begin
					baud_cnt <= '0;
					// Falling edge starts a frame
					if (rx_en && rxd_last && !rxd_sync)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: if (half_done) begin
					baud_cnt <= '0;
					bit_cnt <= '0;
					// High line at mid start bit is a glitch
					state <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
				end
				uart_pkg::RX_DATA: if (bit_done) begin
					baud_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'(uart_pkg::DATA_W - 1))
						state <= uart_pkg::RX_STOP;
				end
				uart_pkg::RX_STOP: if (bit_done) begin
					baud_cnt <= '0;
					frame_done <= 1'b1;
					state <= uart_pkg::RX_IDLE;
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first and shifts down
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && bit_done)
			byte_out <= {rxd_sync, byte_out[uart_pkg::DATA_W-1:1]};
		if (state == uart_pkg::RX_STOP && bit_done)
			stop_ok <= rxd_sync;
	end

endmodule

// ==== uart_core/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
	input logic clk,
	input logic reset,
	input logic tx_en,
	input logic flow_en,
	input logic cts,
	input logic [uart_pkg::DIV_W-1:0] baud_div,
	input logic fifo_empty,
	input logic [uart_pkg::DATA_W-1:0] fifo_data,
	output logic fifo_pop,
	output logic txd,
	output logic busy
);

	uart_pkg::tx_state_e state;
	logic [uart_pkg::DIV_W-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic [uart_pkg::DATA_W-1:0] shift;
	logic bit_done;
	logic can_start;
	logic start_frame;

	// Last clock of the current bit
	assign bit_done = (baud_cnt == baud_div - 1'b1);
	// cts only matters with flow control on
	assign can_start = tx_en && !fifo_empty && (!flow_en || cts);
	// Start from idle, or chain straight out of a finishing stop bit
	assign start_frame = can_start && ((state == uart_pkg::TX_IDLE) ||
		(state == uart_pkg::TX_STOP && bit_done));
	assign fifo_pop = start_frame;
	assign busy = (state != uart_pkg::TX_IDLE);

	// ************************************************************
	// Frame FSM
	// ************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else if (start_frame) begin
			// Start bit
			state <= uart_pkg::TX_START;
			baud_cnt <= '0;
			txd <= 1'b0;
		end else begin
			baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
			case (state)
				uart_pkg::TX_IDLE: begin
					baud_cnt <= '0;
					txd <= 1'b1;
				end
				uart_pkg::TX_START: if (bit_done) begin
					state <= uart_pkg::TX_DATA;
					bit_cnt <= '0;
					txd <= shift[0];
				end
				uart_pkg::TX_DATA: if (bit_done) begin
					if (bit_cnt == 3'(uart_pkg::DATA_W - 1)) begin
						// Stop bit
						state <= uart_pkg::TX_STOP;
						txd <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						txd <= shift[0];
					end
				end
				uart_pkg::TX_STOP: if (bit_done)
					state <= uart_pkg::TX_IDLE;
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// LSB first, next bit always waits in shift[0]
	always_ff @(posedge clk) begin
		if (start_frame)
			shift <= fifo_data;
		else if (bit_done && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA))
			shift <= shift >> 1;
	end

endmodule

// ==== uart_core/uart_fifo.sv ====
`timescale 1ns/100ps

module uart_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [uart_pkg::DATA_W-1:0] wdata,
	input logic pop,
	output logic [uart_pkg::DATA_W-1:0] rdata,
	output logic empty,
	output logic full,
	output logic [uart_pkg::FIFO_CNT_W-1:0] count
);

	// Storage and pointers, depth is a power of two so pointers wrap
	logic [uart_pkg::DATA_W-1:0] mem [uart_pkg::FIFO_DEPTH];
	logic [uart_pkg::FIFO_CNT_W-2:0] wr_ptr;
	logic [uart_pkg::FIFO_CNT_W-2:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// Guard against overflow and underflow
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == uart_pkg::FIFO_DEPTH);
	// Show-ahead head
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

// ==== common/uart_pkg.sv ====
package uart_pkg;

	// ************************************************************
	// Sizes
	// ************************************************************
	localparam int DATA_W = 8;
	localparam int FIFO_DEPTH = 8;
	// Count runs 0 to FIFO_DEPTH inclusive
	localparam int FIFO_CNT_W = 4;
	// Register index comes from address bits 4 to 2
	localparam int REG_INDEX_W = 3;
	localparam int DIV_W = 16;
	localparam logic [DIV_W-1:0] BAUD_RESET = 16'd16;

	// Register map
	typedef enum logic [REG_INDEX_W-1:0] {
		REG_DATA = 3'd0,
		REG_STATUS = 3'd1,
		REG_CTRL = 3'd2,
		REG_BAUD = 3'd3,
		REG_IRQ_EN = 3'd4
	} uart_reg_e;

	// CTRL bit positions
	localparam int CTRL_TX_EN = 0;
	localparam int CTRL_RX_EN = 1;
	localparam int CTRL_FLOW_EN = 2;
	localparam int CTRL_RTS = 3;
	localparam int CTRL_DTR = 4;
	localparam int CTRL_W = 5;

	// STATUS bit positions
	localparam int ST_TX_EMPTY = 0;
	localparam int ST_TX_FULL = 1;
	localparam int ST_RX_EMPTY = 2;
	localparam int ST_RX_FULL = 3;
	localparam int ST_OVERRUN = 4;
	localparam int ST_FRAME_ERR = 5;
	localparam int ST_TX_BUSY = 6;
	// Modem input pins
	localparam int ST_CTS = 8;
	localparam int ST_DSR = 9;
	localparam int ST_DCD = 10;
	localparam int ST_RI = 11;

	// Interrupt enable bit positions
	localparam int IRQ_RX_AVAIL = 0;
	localparam int IRQ_TX_EMPTY = 1;
	localparam int IRQ_ERROR = 2;
	localparam int IRQ_EN_W = 3;

	// ************************************************************
	// FSM states
	// ************************************************************
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage
